/* hw/wbPkg.sv */
`default_nettype none

package wbPkg;

    typedef enum logic [1:0] {memNone, memRead, memWrite} memOp;

    // Master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [7:0]  datWr;
    } wbRequest;

    typedef struct packed {
        logic       ack;
        logic [7:0] datRd;
    } wbResponse;

endpackage

`default_nettype wire

/* hw/busPkg.sv */
`default_nettype none

package busPkg;

    // Bus driver choices where none leaves the bus at zero
    typedef enum logic [2:0] {
        dbNone, dbPsr, dbPch, dbPcl, dbAcc, dbDataIn, dbHigh
    } dbSource;

    typedef enum logic [2:0] {
        sbNone, sbX, sbY, sbSp, sbAluHold, sbAcc, sbHigh
    } sbSource;

    typedef enum logic [2:0] {
        adlNone, adlSp, adlAluHold, adlPcl, adlDataIn, adlZero
    } adlSource;

    typedef enum logic [2:0] {
        adhNone, adhPch, adhDataIn, adhZero, adhOne
    } adhSource;

    typedef enum logic [2:0] {
        aluSum, aluAnd, aluXor, aluOr, aluShiftRight
    } aluOperation;

    typedef enum logic {aSelStack, aSelZero} aluASelect;
    typedef enum logic [1:0] {bSelData, bSelDataInv, bSelAddrLow} aluBSelect;
    typedef enum logic [1:0] {carryZero, carryOne, carryStatus} carrySelect;
    typedef enum logic [1:0] {pcHold, pcIncrement, pcLoad} pcMode;

    typedef struct packed {
        logic x;
        logic y;
        logic acc;
        logic sp;
        logic aluHold;
        logic dor;
        logic abl;
        logic abh;
    } registerLoads;

    typedef struct packed {
        logic carryFromAlu;
        logic overflowFromAlu;
        logic zeroNegFromDb;
        logic loadFromDb;      // Whole PSR from the data bus
        logic setCarry;
        logic clearCarry;
        logic setInterrupt;
        logic clearInterrupt;
        logic setDecimal;
        logic clearDecimal;
        logic setOverflow;
        logic clearOverflow;
    } statusUpdate;

    typedef struct packed {
        dbSource      dbSel;
        sbSource      sbSel;
        adlSource     adlSel;
        adhSource     adhSel;
        logic         dbToSb;
        logic         sbToDb;
        logic         adhToSb;
        logic         sbToAdh;
        aluOperation  aluOp;
        aluASelect    aluA;
        aluBSelect    aluB;
        carrySelect   carrySel;
        pcMode        pcControl;
        registerLoads loads;
        statusUpdate  update;
        wbPkg::memOp  memory;
    } microOp;

    typedef struct packed {
        logic carry;
        logic overflow;
    } aluFlags;

endpackage

`default_nettype wire

/* hw/busNetwork.sv */
`timescale 1ns/1ns
`default_nettype none

module busNetwork (
    input  busPkg::microOp uop,
    input  logic [7:0]     x,
    input  logic [7:0]     y,
    input  logic [7:0]     acc,
    input  logic [7:0]     sp,
    input  logic [7:0]     aluHold,
    input  logic [7:0]     pcl,
    input  logic [7:0]     pch,
    input  logic [7:0]     psr,
    input  logic [7:0]     dataIn,
    output logic [7:0]     dataBus,
    output logic [7:0]     stackBus,
    output logic [7:0]     addrLowBus,
    output logic [7:0]     addrHighBus
);
    import busPkg::*;

    // Values on each bus before any bridge
    logic [7:0] dbDriven, sbDriven, adlDriven, adhDriven;

    always_comb begin
        case (uop.dbSel)
            dbPsr:    dbDriven = psr;
            dbPch:    dbDriven = pch;
            dbPcl:    dbDriven = pcl;
            dbAcc:    dbDriven = acc;
            dbDataIn: dbDriven = dataIn;
            dbHigh:   dbDriven = 8'hFF;
            default:  dbDriven = 8'h00;
        endcase
        case (uop.sbSel)
            sbX:       sbDriven = x;
            sbY:       sbDriven = y;
            sbSp:      sbDriven = sp;
            sbAluHold: sbDriven = aluHold;
            sbAcc:     sbDriven = acc;
            sbHigh:    sbDriven = 8'hFF;
            default:   sbDriven = 8'h00;
        endcase
        case (uop.adlSel)
            adlSp:      adlDriven = sp;
            adlAluHold: adlDriven = aluHold;
            adlPcl:     adlDriven = pcl;
            adlDataIn:  adlDriven = dataIn;
            adlZero:    adlDriven = 8'h00;
            default:    adlDriven = 8'h00;
        endcase
        case (uop.adhSel)
            adhPch:    adhDriven = pch;
            adhDataIn: adhDriven = dataIn;
            adhOne:    adhDriven = 8'h01;
            default:   adhDriven = 8'h00;  // None and zero preset
        endcase
    end

    // Stack bus sits in the middle, so bridged values pass through it
    assign stackBus = sbDriven
                    | (uop.dbToSb ? dbDriven : 8'h00)
                    | (uop.adhToSb ? adhDriven : 8'h00);
    assign dataBus = dbDriven | (uop.sbToDb ? stackBus : 8'h00);
    assign addrHighBus = adhDriven | (uop.sbToAdh ? stackBus : 8'h00);
    assign addrLowBus = adlDriven;

    always_comb begin
        assert (!(uop.sbToDb && uop.dbToSb && uop.dbSel != dbNone && uop.sbSel != sbNone))
            else $error("Data and stack bus both driven through a two-way bridge");
    end

endmodule

`default_nettype wire

/* hw/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  busPkg::microOp  uop,
    input  logic [7:0]      dataBus,
    input  logic [7:0]      stackBus,
    input  logic [7:0]      addrLowBus,
    input  logic            statusCarry,
    output logic [7:0]      result,
    output busPkg::aluFlags flags
);
    import busPkg::*;

    logic [7:0] operandA, operandB;
    logic       carryIn;
    logic [8:0] sum;

    always_comb begin
        operandA = (uop.aluA == aSelZero) ? 8'h00 : stackBus;
        case (uop.aluB)
            bSelDataInv: operandB = ~dataBus;  // Subtract path
            bSelAddrLow: operandB = addrLowBus;
            default:     operandB = dataBus;
        endcase
        case (uop.carrySel)
            carryOne:    carryIn = 1'b1;
            carryStatus: carryIn = statusCarry;
            default:     carryIn = 1'b0;
        endcase
    end

    assign sum = {1'b0, operandA} + {1'b0, operandB} + {8'h00, carryIn};

    always_comb begin
        flags = '0;
        case (uop.aluOp)
            aluSum: begin
                result = sum[7:0];
                flags.carry = sum[8];
                // Like-signed operands giving a result of the other sign
                flags.overflow = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);
            end
            aluAnd: result = operandA & operandB;
            aluXor: result = operandA ^ operandB;
            aluOr:  result = operandA | operandB;
            aluShiftRight: begin
                result = {carryIn, operandA[7:1]};  // Carry in enters at the top
                flags.carry = operandA[0];
            end
            default: result = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* hw/statusRegister.sv */
`timescale 1ns/1ns
`default_nettype none

module statusRegister (
    input  logic                clk,
    input  logic                rst,
    input  logic                commit,
    input  busPkg::statusUpdate update,
    input  logic [7:0]          dataBus,
    input  busPkg::aluFlags     flags,
    output logic [7:0]          status
);
    // N V 1 B D I Z C
    localparam int CarryBit = 0;
    localparam int ZeroBit = 1;
    localparam int InterruptBit = 2;
    localparam int DecimalBit = 3;
    localparam int OverflowBit = 6;
    localparam int NegativeBit = 7;

    logic [7:0] flagsReg, flagsNext;

    always_comb begin
        flagsNext = flagsReg;
        if (update.loadFromDb) flagsNext = dataBus;
        if (update.carryFromAlu) flagsNext[CarryBit] = flags.carry;
        if (update.overflowFromAlu) flagsNext[OverflowBit] = flags.overflow;
        if (update.zeroNegFromDb) begin
            flagsNext[ZeroBit] = (dataBus == 8'h00);
            flagsNext[NegativeBit] = dataBus[7];
        end
        // Explicit set and clear win over everything else
        if (update.setCarry) flagsNext[CarryBit] = 1'b1;
        if (update.clearCarry) flagsNext[CarryBit] = 1'b0;
        if (update.setInterrupt) flagsNext[InterruptBit] = 1'b1;
        if (update.clearInterrupt) flagsNext[InterruptBit] = 1'b0;
        if (update.setDecimal) flagsNext[DecimalBit] = 1'b1;
        if (update.clearDecimal) flagsNext[DecimalBit] = 1'b0;
        if (update.setOverflow) flagsNext[OverflowBit] = 1'b1;
        if (update.clearOverflow) flagsNext[OverflowBit] = 1'b0;
        flagsNext[5] = 1'b0;  // Unused bit reads back as one
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flagsReg <= '0;
        end else if (commit) begin
            flagsReg <= flagsNext;
        end
    end

    assign status = flagsReg | 8'h20;

    setClearExclusive: assert property (@(posedge clk) disable iff (rst)
        commit |-> !((update.setCarry && update.clearCarry)
                  || (update.setInterrupt && update.clearInterrupt)
                  || (update.setDecimal && update.clearDecimal)
                  || (update.setOverflow && update.clearOverflow)));

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
    parameter logic [15:0] ResetVector = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 commit,
    input  busPkg::registerLoads loads,
    input  busPkg::pcMode        pcControl,
    input  logic [7:0]           dataBus,
    input  logic [7:0]           stackBus,
    input  logic [7:0]           addrLowBus,
    input  logic [7:0]           addrHighBus,
    input  logic [7:0]           aluResult,
    output logic [7:0]           x,
    output logic [7:0]           y,
    output logic [7:0]           acc,
    output logic [7:0]           sp,
    output logic [7:0]           aluHold,
    output logic [7:0]           dor,
    output logic [7:0]           abl,
    output logic [7:0]           abh,
    output logic [7:0]           pcl,
    output logic [7:0]           pch
);
    import busPkg::*;

    logic [15:0] pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
            y <= '0;
            acc <= '0;
            sp <= '0;
            aluHold <= '0;
            dor <= '0;
            abl <= '0;
            abh <= '0;
            pc <= ResetVector;
        end else if (commit) begin
            if (loads.x) x <= stackBus;
            if (loads.y) y <= stackBus;
            if (loads.acc) acc <= stackBus;
            if (loads.sp) sp <= stackBus;
            if (loads.aluHold) aluHold <= aluResult;
            if (loads.dor) dor <= dataBus;      // Write data for the next store
            if (loads.abl) abl <= addrLowBus;
            if (loads.abh) abh <= addrHighBus;
            case (pcControl)
                pcIncrement: pc <= pc + 16'd1;
                pcLoad:      pc <= {addrHighBus, addrLowBus};  // Jump target
                default:     pc <= pc;
            endcase
        end
    end

    assign pcl = pc[7:0];
    assign pch = pc[15:8];

endmodule

`default_nettype wire

/* hw/internalDataflow.sv */
`timescale 1ns/1ns
`default_nettype none

module internalDataflow #(
    parameter logic [15:0] ResetVector = 16'h0000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           execValid,
    input  logic           stall,
    input  busPkg::microOp uop,
    input  logic [7:0]     dataIn,
    output logic [15:0]    address,
    output logic [7:0]     dorValue,
    output logic [7:0]     status
);
    import busPkg::*;

    logic       commit;  // Micro-op finishes on this edge
    logic [7:0] x, y, acc, sp, aluHold, dor, abl, abh, pcl, pch;
    logic [7:0] dataBus, stackBus, addrLowBus, addrHighBus;
    logic [7:0] aluResult;
    aluFlags    flags;

    assign commit = execValid && !stall;

    busNetwork buses (
        .uop(uop), .x(x), .y(y), .acc(acc), .sp(sp), .aluHold(aluHold),
        .pcl(pcl), .pch(pch), .psr(status), .dataIn(dataIn),
        .dataBus(dataBus), .stackBus(stackBus),
        .addrLowBus(addrLowBus), .addrHighBus(addrHighBus)
    );

    aluUnit alu (
        .uop(uop), .dataBus(dataBus), .stackBus(stackBus), .addrLowBus(addrLowBus),
        .statusCarry(status[0]),
        .result(aluResult), .flags(flags)
    );

    statusRegister psr (
        .clk(clk), .rst(rst), .commit(commit), .update(uop.update),
        .dataBus(dataBus), .flags(flags), .status(status)
    );

    registerFile #(
        .ResetVector(ResetVector)
    ) regs (
        .clk(clk), .rst(rst), .commit(commit),
        .loads(uop.loads), .pcControl(uop.pcControl),
        .dataBus(dataBus), .stackBus(stackBus),
        .addrLowBus(addrLowBus), .addrHighBus(addrHighBus), .aluResult(aluResult),
        .x(x), .y(y), .acc(acc), .sp(sp), .aluHold(aluHold), .dor(dor),
        .abl(abl), .abh(abh), .pcl(pcl), .pch(pch)
    );

    // External address and write data come straight from ABH/ABL and DOR
    assign address = {abh, abl};
    assign dorValue = dor;

endmodule

`default_nettype wire

/* hw/memoryPort.sv */
`timescale 1ns/1ns
`default_nettype none

module memoryPort (
    input  logic             clk,
    input  logic             rst,
    input  logic             execValid,
    input  wbPkg::memOp      kind,
    input  logic [15:0]      address,
    input  logic [7:0]       dorValue,
    input  wbPkg::wbResponse wbResp,
    output wbPkg::wbRequest  wbReq,
    output logic             stall,
    output logic [7:0]       dataIn
);
    import wbPkg::*;

    typedef enum logic {portIdle, portBusy} portState;

    portState    state;
    logic        start;
    logic        writeCycle;
    logic [15:0] adrHeld;
    logic [7:0]  datHeld;

    assign start = execValid && (kind != memNone) && (state == portIdle);
    // Memory op holds execute until its ack
    assign stall = execValid && (kind != memNone) && !((state == portBusy) && wbResp.ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= portIdle;
            writeCycle <= 1'b0;
            dataIn <= '0;
        end else if (start) begin
            state <= portBusy;
            writeCycle <= (kind == memWrite);
        end else if ((state == portBusy) && wbResp.ack) begin
            state <= portIdle;  // cyc drops the cycle after ack
            if (!writeCycle) dataIn <= wbResp.datRd;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adrHeld <= address;
            datHeld <= dorValue;
        end
    end

    always_comb begin
        wbReq.cyc = (state == portBusy);
        wbReq.stb = (state == portBusy);
        wbReq.we = (state == portBusy) && writeCycle;
        wbReq.adr = adrHeld;
        wbReq.datWr = datHeld;
    end

    ackInsideCycle: assert property (@(posedge clk) disable iff (rst)
        wbResp.ack |-> wbReq.cyc);

endmodule

`default_nettype wire

/* hw/cpuCore.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuCore #(
    parameter logic [15:0] ResetVector = 16'hC000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             opValid,
    input  busPkg::microOp   op,
    input  wbPkg::wbResponse wbResp,
    output logic             opReady,
    output wbPkg::wbRequest  wbReq,
    output logic [7:0]       status
);
    import busPkg::*;

    microOp      execOp;
    logic        execValid;
    logic        stall;
    logic [15:0] address;
    logic [7:0]  dorValue, dataIn;

    assign opReady = !execValid || !stall;  // Empty or completing

    always_ff @(posedge clk) begin
        if (rst) begin
            execValid <= 1'b0;
            execOp <= '0;
        end else if (opReady) begin
            execValid <= opValid;
            if (opValid) execOp <= op;
        end
    end

    internalDataflow #(
        .ResetVector(ResetVector)
    ) dataflow (
        .clk(clk), .rst(rst), .execValid(execValid), .stall(stall),
        .uop(execOp), .dataIn(dataIn),
        .address(address), .dorValue(dorValue), .status(status)
    );

    memoryPort memPort (
        .clk(clk), .rst(rst), .execValid(execValid), .kind(execOp.memory),
        .address(address), .dorValue(dorValue), .wbResp(wbResp),
        .wbReq(wbReq), .stall(stall), .dataIn(dataIn)
    );

    // Stalled word stays in the execute register until it completes
    noAcceptDuringStall: assert property (@(posedge clk) disable iff (rst)
        (execValid && stall) |=> (execValid && $stable(execOp)));

endmodule

`default_nettype wire

/* tests/wbMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module wbMemory (
    input  logic             clk,
    input  logic             rst,
    input  wbPkg::wbRequest  wbReq,
    output wbPkg::wbResponse wbResp
);
    logic [7:0] mem [0:65535];
    logic [2:0] waitLeft;  // Cycles still to wait before ack

    // Scrambled fill so that every address bit changes the byte
    function automatic logic [7:0] fillByte(input logic [15:0] a);
        return (a[7:0] * 8'd37) ^ (a[15:8] * 8'd101) ^ 8'hA5;
    endfunction

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fillByte(16'(a));
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wbResp.ack <= 1'b0;
            wbResp.datRd <= 8'h00;
            waitLeft <= 3'd0;
        end else if (wbReq.cyc && wbReq.stb && !wbResp.ack) begin
            if (waitLeft == 3'd0) begin
                wbResp.ack <= 1'b1;
                if (wbReq.we) begin
                    mem[wbReq.adr] <= wbReq.datWr;
                end else begin
                    wbResp.datRd <= mem[wbReq.adr];
                end
                waitLeft <= 3'($urandom_range(5, 0));  // Wait states for the next access
            end else begin
                waitLeft <= waitLeft - 3'd1;
            end
        end else begin
            wbResp.ack <= 1'b0;  // Ack lasts a single cycle
        end
    end

endmodule

`default_nettype wire

/* tests/cpuCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;
    import busPkg::*;
    import wbPkg::*;

    localparam logic [15:0] ResetVector = 16'hC000;
    localparam int RandomOps = 300;
    localparam int CyclesPerOp = 40;

    typedef struct packed {
        logic [7:0]  x, y, acc, sp, aluHold, dor, abl, abh;
        logic [15:0] pc;
        logic [7:0]  flags;  // Bit 5 kept at zero here
        logic [7:0]  dataIn;
    } modelState;

    typedef struct packed {
        logic        we;
        logic [15:0] adr;
        logic [7:0]  dat;
    } transferRecord;

    logic      clk, rst, opValid, opReady;
    microOp    op;
    wbRequest  wbReq;
    wbResponse wbResp;
    logic [7:0] status;

    modelState     model;
    logic [7:0]    modelMem [0:65535];
    logic [7:0]    expectedStatus [$];
    transferRecord expectedXfers [$];
    int issuedOps = 0;
    int cycleCount = 0;

    // Monitor bookkeeping
    logic          execPending;
    logic          statusDue;
    logic [7:0]    statusWant;
    transferRecord transferWant;
    int completions = 0;
    int statusChecked = 0;
    int transfersChecked = 0;

    cpuCore #(
        .ResetVector(ResetVector)
    ) dut (
        .clk(clk), .rst(rst), .opValid(opValid), .op(op), .wbResp(wbResp),
        .opReady(opReady), .wbReq(wbReq), .status(status)
    );

    wbMemory slaveMemory (
        .clk(clk), .rst(rst), .wbReq(wbReq), .wbResp(wbResp)
    );

    function automatic logic [7:0] fillByte(input logic [15:0] a);
        return (a[7:0] * 8'd37) ^ (a[15:8] * 8'd101) ^ 8'hA5;
    endfunction

    // Expected machine state after one micro-op
    function automatic modelState nextState(input modelState s, input microOp u,
                                            input logic [7:0] readByte);
        modelState  n;
        logic [7:0] dbV, sbV, adlV, adhV, db, sb, adh, opA, opB, res, f;
        logic       cin, cout, ovf;
        int         total, signedSum;
        n = s;
        case (u.dbSel)
            dbPsr:    dbV = s.flags | 8'h20;
            dbPch:    dbV = s.pc[15:8];
            dbPcl:    dbV = s.pc[7:0];
            dbAcc:    dbV = s.acc;
            dbDataIn: dbV = s.dataIn;
            dbHigh:   dbV = 8'hFF;
            default:  dbV = 8'h00;
        endcase
        case (u.sbSel)
            sbX:       sbV = s.x;
            sbY:       sbV = s.y;
            sbSp:      sbV = s.sp;
            sbAluHold: sbV = s.aluHold;
            sbAcc:     sbV = s.acc;
            sbHigh:    sbV = 8'hFF;
            default:   sbV = 8'h00;
        endcase
        case (u.adlSel)
            adlSp:      adlV = s.sp;
            adlAluHold: adlV = s.aluHold;
            adlPcl:     adlV = s.pc[7:0];
            adlDataIn:  adlV = s.dataIn;
            default:    adlV = 8'h00;
        endcase
        case (u.adhSel)
            adhPch:    adhV = s.pc[15:8];
            adhDataIn: adhV = s.dataIn;
            adhOne:    adhV = 8'h01;
            default:   adhV = 8'h00;
        endcase
        // Stack bus first since both bridges meet there
        sb = sbV;
        if (u.dbToSb) sb |= dbV;
        if (u.adhToSb) sb |= adhV;
        db = dbV;
        if (u.sbToDb) db |= sb;
        adh = adhV;
        if (u.sbToAdh) adh |= sb;
        opA = (u.aluA == aSelZero) ? 8'h00 : sb;
        case (u.aluB)
            bSelDataInv: opB = ~db;
            bSelAddrLow: opB = adlV;
            default:     opB = db;
        endcase
        case (u.carrySel)
            carryOne:    cin = 1'b1;
            carryStatus: cin = s.flags[0];
            default:     cin = 1'b0;
        endcase
        total = int'(opA) + int'(opB) + int'(cin);
        signedSum = int'($signed(opA)) + int'($signed(opB)) + int'(cin);
        cout = 1'b0;
        ovf = 1'b0;
        case (u.aluOp)
            aluSum: begin
                res = total[7:0];
                cout = (total > 255);
                ovf = (signedSum > 127) || (signedSum < -128);  // Out of signed byte range
            end
            aluAnd: res = opA & opB;
            aluXor: res = opA ^ opB;
            aluOr:  res = opA | opB;
            aluShiftRight: begin
                res = {cin, opA[7:1]};
                cout = opA[0];
            end
            default: res = 8'h00;
        endcase
        f = s.flags;
        if (u.update.loadFromDb) f = db;
        if (u.update.carryFromAlu) f[0] = cout;
        if (u.update.overflowFromAlu) f[6] = ovf;
        if (u.update.zeroNegFromDb) begin
            f[1] = (db == 8'h00);
            f[7] = db[7];
        end
        if (u.update.setCarry) f[0] = 1'b1;
        if (u.update.clearCarry) f[0] = 1'b0;
        if (u.update.setInterrupt) f[2] = 1'b1;
        if (u.update.clearInterrupt) f[2] = 1'b0;
        if (u.update.setDecimal) f[3] = 1'b1;
        if (u.update.clearDecimal) f[3] = 1'b0;
        if (u.update.setOverflow) f[6] = 1'b1;
        if (u.update.clearOverflow) f[6] = 1'b0;
        f[5] = 1'b0;
        n.flags = f;
        if (u.loads.x) n.x = sb;
        if (u.loads.y) n.y = sb;
        if (u.loads.acc) n.acc = sb;
        if (u.loads.sp) n.sp = sb;
        if (u.loads.aluHold) n.aluHold = res;
        if (u.loads.dor) n.dor = db;
        if (u.loads.abl) n.abl = adlV;
        if (u.loads.abh) n.abh = adh;
        if (u.pcControl == pcIncrement) n.pc = s.pc + 16'd1;
        if (u.pcControl == pcLoad) n.pc = {adh, adlV};
        if (u.memory == memRead) n.dataIn = readByte;
        return n;
    endfunction

    // Random micro-op with at most one bridge and no flag both set and cleared
    function automatic microOp randomOp();
        microOp      u;
        statusUpdate upd;
        u = '0;
        u.dbSel = dbSource'(3'($urandom_range(6, 0)));
        u.sbSel = sbSource'(3'($urandom_range(6, 0)));
        u.adlSel = adlSource'(3'($urandom_range(5, 0)));
        u.adhSel = adhSource'(3'($urandom_range(4, 0)));
        case ($urandom_range(5, 0))
            1: u.dbToSb = 1'b1;
            2: u.sbToDb = 1'b1;
            3: u.adhToSb = 1'b1;
            4: u.sbToAdh = 1'b1;
            default: ;
        endcase
        u.aluOp = aluOperation'(3'($urandom_range(4, 0)));
        u.aluA = aluASelect'(1'($urandom_range(1, 0)));
        u.aluB = aluBSelect'(2'($urandom_range(2, 0)));
        u.carrySel = carrySelect'(2'($urandom_range(2, 0)));
        u.pcControl = pcMode'(2'($urandom_range(2, 0)));
        u.loads = registerLoads'(8'($urandom_range(255, 0)));
        upd = statusUpdate'(12'($urandom_range(4095, 0)));
        if (upd.setCarry && upd.clearCarry) upd.clearCarry = 1'b0;
        if (upd.setInterrupt && upd.clearInterrupt) upd.clearInterrupt = 1'b0;
        if (upd.setDecimal && upd.clearDecimal) upd.clearDecimal = 1'b0;
        if (upd.setOverflow && upd.clearOverflow) upd.clearOverflow = 1'b0;
        u.update = upd;
        u.memory = memOp'(2'($urandom_range(2, 0)));
        return u;
    endfunction

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Advance the model, record expectations, then hand the word to the DUT
    task automatic issue(input microOp u);
        logic [15:0]   addr;
        logic [7:0]    readByte;
        logic          accepted;
        transferRecord rec;
        addr = {model.abh, model.abl};
        readByte = modelMem[addr];
        if (u.memory != memNone) begin
            rec.we = (u.memory == memWrite);
            rec.adr = addr;
            rec.dat = model.dor;
            expectedXfers.push_back(rec);
        end
        if (u.memory == memWrite) modelMem[addr] = model.dor;
        model = nextState(model, u, readByte);
        expectedStatus.push_back(model.flags | 8'h20);
        issuedOps++;
        if ($urandom_range(7, 0) == 0) begin
            opValid = 1'b0;  // Idle cycle empties the execute stage
            @(posedge clk);
            #2;
        end
        opValid = 1'b1;
        op = u;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = opReady;
            @(posedge clk);
            #2;
        end
        opValid = 1'b0;
    endtask

    task automatic runDirected();
        microOp u;
        u = '0;
        u.sbSel = sbHigh;
        u.loads.x = 1'b1;
        u.loads.sp = 1'b1;
        u.pcControl = pcIncrement;
        issue(u);
        u = '0;
        u.adlSel = adlSp;
        u.adhSel = adhOne;  // Stack page
        u.loads.abl = 1'b1;
        u.loads.abh = 1'b1;
        u.pcControl = pcIncrement;
        issue(u);
        u = '0;
        u.memory = memRead;
        issue(u);
        u = '0;
        u.dbSel = dbDataIn;
        u.dbToSb = 1'b1;
        u.loads.y = 1'b1;
        u.update.zeroNegFromDb = 1'b1;
        issue(u);
        u = '0;
        u.sbSel = sbY;
        u.sbToDb = 1'b1;
        u.loads.dor = 1'b1;
        issue(u);
        u = '0;
        u.memory = memWrite;
        u.update.setCarry = 1'b1;
        u.update.setOverflow = 1'b1;
        u.update.setDecimal = 1'b1;
        issue(u);
        u = '0;
        u.sbSel = sbX;
        u.dbSel = dbDataIn;
        u.carrySel = carryStatus;
        u.loads.aluHold = 1'b1;
        u.update.carryFromAlu = 1'b1;
        u.update.overflowFromAlu = 1'b1;
        u.update.clearDecimal = 1'b1;
        issue(u);
        u = '0;
        u.adlSel = adlAluHold;
        u.adhSel = adhDataIn;
        u.pcControl = pcLoad;  // Jump to dataIn:aluHold
        issue(u);
        u = '0;
        u.adlSel = adlPcl;
        u.adhSel = adhPch;
        u.dbSel = dbPsr;
        u.loads.abl = 1'b1;
        u.loads.abh = 1'b1;
        u.loads.dor = 1'b1;
        issue(u);
        u = '0;
        u.memory = memWrite;
        u.dbSel = dbHigh;
        u.update.loadFromDb = 1'b1;
        issue(u);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CyclesPerOp * (issuedOps + 1) + 20) begin
            stopWithFailure($sformatf("timeout after %0d cycles with %0d micro-ops issued",
                                      cycleCount, issuedOps));
        end
    end

    // Values at the falling edge are the ones the next rising edge samples
    always @(negedge clk) begin
        if (rst) begin
            execPending = 1'b0;
            statusDue = 1'b0;
        end else begin
            if (statusDue) begin
                assert (status == statusWant)
                    else stopWithFailure($sformatf("mismatch at %0t ns: status %02h, expected %02h",
                                                   $time, status, statusWant));
                statusDue = 1'b0;
                statusChecked++;
            end
            if (wbReq.cyc && wbReq.stb && wbResp.ack) begin
                assert (transfersChecked < expectedXfers.size())
                    else stopWithFailure("Wishbone transfer seen with no memory micro-op pending");
                transferWant = expectedXfers[transfersChecked];
                assert (wbReq.we == transferWant.we && wbReq.adr == transferWant.adr
                        && wbReq.datWr == transferWant.dat)
                    else stopWithFailure($sformatf(
                        "mismatch at %0t ns: we %0b adr %04h dat %02h, expected %0b %04h %02h",
                        $time, wbReq.we, wbReq.adr, wbReq.datWr,
                        transferWant.we, transferWant.adr, transferWant.dat));
                transfersChecked++;
            end
            if (execPending && opReady) begin
                assert (completions < expectedStatus.size())
                    else stopWithFailure("micro-op completed that was never issued");
                statusWant = expectedStatus[completions];
                completions++;
                statusDue = 1'b1;  // Checked after the completing edge
            end
            if (opReady) execPending = opValid;
        end
    end

    initial begin
        void'($urandom(12396));
        rst = 1'b1;
        opValid = 1'b0;
        op = '0;
        model = '0;
        model.pc = ResetVector;
        for (int a = 0; a < 65536; a++) begin
            modelMem[a] = fillByte(16'(a));
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        runDirected();
        repeat (RandomOps) issue(randomOp());
        opValid = 1'b0;
        while (statusChecked < expectedStatus.size()) @(posedge clk);
        assert (transfersChecked == expectedXfers.size())
            else stopWithFailure("expected Wishbone transfers never took place");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/wbPkg.sv
hw/busPkg.sv
hw/busNetwork.sv
hw/aluUnit.sv
hw/statusRegister.sv
hw/registerFile.sv
hw/internalDataflow.sv
hw/memoryPort.sv
hw/cpuCore.sv
tests/wbMemory.sv
tests/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module cpuCoreTb -f src.f -o cpuCoreSim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuCoreSim
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit "$simStatus"
fi

exit 0
